// File: tb/backend_testdata.txt
// test pc instr kind(0 none 1 store 2 redirect) addr_or_target data
// test 1 alu chain, test 2 load and store, test 3 branches, test 4 jal, test 5 nops and stall
1 1000 12300093 0 0 0
1 1004 ffb00113 0 0 0
1 1008 002081b3 0 0 0
1 100c 40208233 0 0 0
1 1010 0041f2b3 0 0 0
1 1014 0022e333 0 0 0
1 1018 004343b3 0 0 0
1 101c 12345437 0 0 0
1 1020 007444b3 0 0 0
1 1024 0490b023 1 163 ffffffffedcbaed3
2 1028 00843503 0 0 0
2 102c 0000b003 0 0 0
2 1030 00a03823 1 10 edcbaff712345008
2 1034 00003c23 1 18 0
3 1038 00108863 2 1048 0
3 103c 00208863 0 0 0
3 1040 fe209ce3 2 1038 0
3 1044 fe109ce3 0 0 0
4 1048 100005ef 2 1148 0
4 104c 02b03023 1 20 104c
5 1050 00000000 0 0 0
5 1054 022081b3 0 0 0
5 1058 02303423 1 28 11e
5 105c 00843503 0 0 0
5 1060 00a03423 1 8 edcbaff712345008

// File: list.f
+incdir+design
design/backend_pkg.sv
design/ctrl_block.sv
design/regfile.sv
design/int_block.sv
design/mem_block.sv
design/backend.sv
tb/backend_sva.sv
tb/tb_backend.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module tb_backend -Mdir obj_dir

run: compile
	./obj_dir/Vtb_backend | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_backend.sv
`timescale 1ns/1ps

`include "backend_defs.svh"

module tb_backend import backend_pkg::*; ();
    localparam int COLS = 6;
    localparam int MAX_LINES = 64;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        ibuffer_instr_valid = 1'b0;
    instr_t      ibuffer_inst_out = '0;
    xlen_t       ibuffer_pc_out = '0;
    logic        ibuffer_ready;
    logic        redirect_valid;
    xlen_t       redirect_target;
    logic        mem_stall;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    xlen_t       wb_adr;
    xlen_t       wb_dat_w;
    logic [`BE_SEL_W-1:0] wb_sel;
    xlen_t       wb_dat_r = '0;
    logic        wb_ack = 1'b0;

    logic [63:0] tdata [COLS*MAX_LINES];
    int          num_lines = 0;
    int          errors = 0;
    int          test_errs = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    integer      seed = 95;
    integer      wait_left = 0;
    logic        slave_busy = 1'b0;

    always #4 clk = ~clk;

    backend backend_inst (.*);

    // slave answers after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            slave_busy = 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!slave_busy) begin
                    slave_busy = 1'b1;
                    wait_left  = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    wb_ack     <= 1'b1;
                    wb_dat_r   <= {~wb_adr[31:0], wb_adr[31:0]};
                    slave_busy = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic close_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_pass++;
        end else begin
            $display("test %s: failed with %0d errors", name, test_errs);
            tests_fail++;
        end
        test_errs = 0;
    endtask

    task automatic check_ctrl_low();
        if (ibuffer_ready !== 1'b0) report_mismatch("ibuffer_ready", 0, ibuffer_ready);
        if (redirect_valid !== 1'b0) report_mismatch("redirect_valid", 0, redirect_valid);
        if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", 0, wb_cyc);
        if (wb_stb !== 1'b0) report_mismatch("wb_stb", 0, wb_stb);
        if (wb_we !== 1'b0) report_mismatch("wb_we", 0, wb_we);
        if (mem_stall !== 1'b0) report_mismatch("mem_stall", 0, mem_stall);
    endtask

    // send one instruction, then watch events until the next fetch slot
    task automatic issue_and_watch(input int idx);
        logic [63:0] kind;
        logic [63:0] exp_a;
        logic [63:0] exp_d;
        logic [63:0] redir_tgt;
        logic [63:0] st_adr;
        logic [63:0] st_dat;
        int          cyc_n;
        int          redir_n;
        int          redir_cyc;
        int          store_n;
        kind    = tdata[idx*COLS+3];
        exp_a   = tdata[idx*COLS+4];
        exp_d   = tdata[idx*COLS+5];
        cyc_n   = 0;
        redir_n = 0;
        redir_cyc = 0;
        store_n = 0;
        @(posedge clk);
        ibuffer_instr_valid <= 1'b1;
        ibuffer_pc_out      <= tdata[idx*COLS+1];
        ibuffer_inst_out    <= tdata[idx*COLS+2][31:0];
        @(negedge clk);
        while (!ibuffer_ready) @(negedge clk);
        @(posedge clk);
        ibuffer_instr_valid <= 1'b0;
        do begin
            @(negedge clk);
            cyc_n++;
            if (redirect_valid) begin
                redir_n++;
                redir_cyc = cyc_n;
                redir_tgt = redirect_target;
            end
            if (wb_cyc && wb_stb && wb_ack && wb_we) begin
                store_n++;
                st_adr = wb_adr;
                st_dat = wb_dat_w;
            end
            if (wb_cyc && wb_sel !== '1) report_mismatch("wb_sel", 64'hff, wb_sel);
            if (wb_cyc && !mem_stall) report_problem("bus cycle while mem_stall is low");
            if (mem_stall && ibuffer_ready) report_problem("ready high during mem_stall");
        end while (!ibuffer_ready);
        if (kind == 2) begin
            if (redir_n != 1) begin
                report_problem("taken branch or jal gave no single redirect pulse");
            end else begin
                if (redir_tgt !== exp_a) report_mismatch("redirect_target", exp_a, redir_tgt);
                if (redir_cyc != 2) report_problem("redirect pulse in the wrong cycle");
            end
        end else if (redir_n != 0) begin
            report_problem("redirect pulse where none was expected");
        end
        if (kind == 1) begin
            if (store_n != 1) begin
                report_problem("expected store did not reach the bus");
            end else begin
                if (st_adr !== exp_a) report_mismatch("wb_adr", exp_a, st_adr);
                if (st_dat !== exp_d) report_mismatch("wb_dat_w", exp_d, st_dat);
            end
        end else if (store_n != 0) begin
            report_problem("unexpected bus write");
        end
    endtask

    initial begin
        $readmemh("tb/backend_testdata.txt", tdata);
        while (num_lines < MAX_LINES && tdata[num_lines*COLS] !== 'x) num_lines++;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) rst <= 1'b0;
            @(negedge clk);
            check_ctrl_low();
        end
        @(negedge clk);
        if (ibuffer_ready !== 1'b1) report_mismatch("ibuffer_ready", 1, ibuffer_ready);
        repeat (3) begin
            @(negedge clk);
            if (wb_cyc !== 1'b0) report_problem("bus cycle started with no instruction");
        end
        close_test("reset");
        for (int i = 0; i < num_lines; i++) begin
            issue_and_watch(i);
            if (i == num_lines - 1 || tdata[(i+1)*COLS] != tdata[i*COLS]) begin
                close_test($sformatf("%0d", tdata[i*COLS]));
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_pass + tests_fail, tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog scaled to the number of data lines
    initial begin
        #1;
        repeat (num_lines * 20 + 20) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tb/backend_sva.sv
`timescale 1ns/1ps

`include "backend_defs.svh"

module backend_sva (
    input logic                clk,
    input logic                rst,
    input logic                ibuffer_instr_valid,
    input logic [`BE_ILEN-1:0] ibuffer_inst_out,
    input logic                ibuffer_ready,
    input logic                mem_stall,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic [`BE_XLEN-1:0] wb_adr,
    input logic                wb_ack
);
    // fetch side holds valid and the instruction until the transfer
    valid_held: assert property (@(posedge clk) disable iff (rst)
        ibuffer_instr_valid && !ibuffer_ready |=>
            ibuffer_instr_valid && $stable(ibuffer_inst_out))
        else $error("fetch valid or instruction changed before transfer");

    // cyc and stb both drop on the ack edge
    cyc_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_ack |=> !wb_cyc && !wb_stb)
        else $error("wb_cyc or wb_stb still high after the ack edge");

    adr_held: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr))
        else $error("wb_adr changed during a pending cycle");

    // no new fetch while a memory op is in flight
    stall_blocks_fetch: assert property (@(posedge clk) disable iff (rst)
        mem_stall |-> !ibuffer_ready)
        else $error("ibuffer_ready high during mem_stall");

endmodule

bind backend backend_sva sva_inst (.*);

// File: design/backend.sv
`timescale 1ns/1ps

`include "backend_defs.svh"

module backend import backend_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ibuffer_instr_valid,
    input  instr_t               ibuffer_inst_out,
    input  xlen_t                ibuffer_pc_out,
    output logic                 ibuffer_ready,
    output logic                 redirect_valid,
    output xlen_t                redirect_target,
    output logic                 mem_stall,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output xlen_t                wb_adr,
    output xlen_t                wb_dat_w,
    output logic [`BE_SEL_W-1:0] wb_sel,
    input  xlen_t                wb_dat_r,
    input  logic                 wb_ack
);
    uop_t      uop;
    logic      alu_issue;
    logic      mem_issue;
    xlen_t     src1;
    xlen_t     src2;
    wb_t       int_wb;
    wb_t       mem_wb;
    wb_t       wb_res;
    redirect_t int_redirect;

    // the two paths never finish in the same cycle
    assign wb_res = int_wb.valid ? int_wb : mem_wb;

    assign redirect_valid  = int_redirect.valid;
    assign redirect_target = int_redirect.target;

    ctrl_block ctrl_inst (
        .clk                 (clk),
        .rst                 (rst),
        .ibuffer_instr_valid (ibuffer_instr_valid),
        .ibuffer_inst_out    (ibuffer_inst_out),
        .ibuffer_pc_out      (ibuffer_pc_out),
        .ibuffer_ready       (ibuffer_ready),
        .retire              (wb_res.valid),
        .uop                 (uop),
        .alu_issue           (alu_issue),
        .mem_issue           (mem_issue),
        .mem_stall           (mem_stall)
    );

    regfile regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (uop.rs1),
        .rs2      (uop.rs2),
        .rd_data1 (src1),
        .rd_data2 (src2),
        .we       (wb_res.valid),
        .wr_idx   (wb_res.rd),
        .wr_data  (wb_res.data)
    );

    int_block int_inst (
        .clk      (clk),
        .rst      (rst),
        .issue    (alu_issue),
        .uop      (uop),
        .src1     (src1),
        .src2     (src2),
        .wb       (int_wb),
        .redirect (int_redirect)
    );

    mem_block mem_inst (
        .clk      (clk),
        .rst      (rst),
        .issue    (mem_issue),
        .uop      (uop),
        .src1     (src1),
        .src2     (src2),
        .wb       (mem_wb),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

// File: design/mem_block.sv
`timescale 1ns/1ps

`include "backend_defs.svh"

module mem_block import backend_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  uop_t                 uop,
    input  xlen_t                src1,
    input  xlen_t                src2,
    output wb_t                  wb,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output xlen_t                wb_adr,
    output xlen_t                wb_dat_w,
    output logic [`BE_SEL_W-1:0] wb_sel,
    input  xlen_t                wb_dat_r,
    input  logic                 wb_ack
);
    typedef enum logic {M_IDLE, M_BUS} mstate_e;

    mstate_e state;
    areg_t   rd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= M_IDLE;
            wb_we    <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= 1'b0;
            case (state)
                M_IDLE: if (issue) begin
                    state    <= M_BUS;
                    wb_we    <= (uop.kind == UOP_STORE);
                    wb_adr   <= src1 + uop.imm;
                    wb_dat_w <= src2;
                    // a store retires with rd zero
                    rd_q     <= (uop.kind == UOP_LOAD) ? uop.rd : '0;
                end
                default: if (wb_ack) begin
                    // load data captured on the ack edge
                    state    <= M_IDLE;
                    wb_we    <= 1'b0;
                    wb.valid <= 1'b1;
                    wb.rd    <= rd_q;
                    wb.data  <= wb_dat_r;
                end
            endcase
        end
    end

    // classic cycle, cyc and stb move together
    assign wb_cyc = (state == M_BUS);
    assign wb_stb = (state == M_BUS);

    // doubleword only, all lanes on
    assign wb_sel = {`BE_SEL_W{1'b1}};

endmodule

// File: design/int_block.sv
`timescale 1ns/1ps

module int_block import backend_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue,
    input  uop_t      uop,
    input  xlen_t     src1,
    input  xlen_t     src2,
    output wb_t       wb,
    output redirect_t redirect
);
    xlen_t op_b;
    xlen_t alu_res;
    logic  taken;
    logic  do_redirect;

    // second operand is rs2 or the immediate
    assign op_b = uop.use_imm ? uop.imm : src2;

    always_comb begin
        case (uop.alu_op)
            ALU_SUB: alu_res = src1 - op_b;
            ALU_AND: alu_res = src1 & op_b;
            ALU_OR:  alu_res = src1 | op_b;
            ALU_XOR: alu_res = src1 ^ op_b;
            default: alu_res = src1 + op_b;
        endcase
    end

    // beq and bne share one comparator
    assign taken = uop.is_bne ? (src1 != src2) : (src1 == src2);

    assign do_redirect = (uop.kind == UOP_JAL) || ((uop.kind == UOP_BRANCH) && taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid       <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            wb.valid        <= issue;
            redirect.valid  <= issue && do_redirect;
            // branches carry rd zero from decode so they write nothing
            wb.rd           <= uop.rd;
            wb.data         <= (uop.kind == UOP_JAL) ? uop.pc + xlen_t'(4) : alu_res;
            redirect.target <= uop.pc + uop.imm;
        end
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

`include "backend_defs.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`BE_AREG_W-1:0] rs1,
    input  logic [`BE_AREG_W-1:0] rs2,
    output logic [`BE_XLEN-1:0]   rd_data1,
    output logic [`BE_XLEN-1:0]   rd_data2,
    input  logic                  we,
    input  logic [`BE_AREG_W-1:0] wr_idx,
    input  logic [`BE_XLEN-1:0]   wr_data
);
    logic [`BE_XLEN-1:0] regs [`BE_NREG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BE_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is never written and keeps its reset value of zero
    assign rd_data1 = regs[rs1];
    assign rd_data2 = regs[rs2];

endmodule

// File: design/ctrl_block.sv
`timescale 1ns/1ps

module ctrl_block import backend_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   ibuffer_instr_valid,
    input  instr_t ibuffer_inst_out,
    input  xlen_t  ibuffer_pc_out,
    output logic   ibuffer_ready,
    input  logic   retire,
    output uop_t   uop,
    output logic   alu_issue,
    output logic   mem_issue,
    output logic   mem_stall
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_e;

    state_e state;
    uop_t   dec;
    instr_t ins;
    xlen_t  imm_i;
    xlen_t  imm_s;
    xlen_t  imm_b;
    xlen_t  imm_u;
    xlen_t  imm_j;
    logic   fire;

    assign ins   = ibuffer_inst_out;
    assign fire  = ibuffer_instr_valid && ibuffer_ready;
    assign imm_i = {{52{ins[31]}}, ins[31:20]};
    assign imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    assign imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    // anything not recognised falls through as a nop
    always_comb begin
        dec        = '0;
        dec.kind   = UOP_NOP;
        dec.alu_op = ALU_ADD;
        dec.pc     = ibuffer_pc_out;
        dec.rs1    = ins[19:15];
        dec.rs2    = ins[24:20];
        case (ins[6:0])
            OPC_OP: begin
                dec.kind = UOP_ALU;
                dec.rd   = ins[11:7];
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_100: dec.alu_op = ALU_XOR;
                    default: begin
                        dec.kind = UOP_NOP;
                        dec.rd   = '0;
                    end
                endcase
            end
            OPC_OP_IMM: if (ins[14:12] == 3'b000) begin
                dec.kind    = UOP_ALU;
                dec.rd      = ins[11:7];
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            OPC_LUI: begin
                // x0 as rs1 gives the zero first operand
                dec.kind    = UOP_ALU;
                dec.rd      = ins[11:7];
                dec.rs1     = '0;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
            end
            OPC_BRANCH: if (ins[14:13] == 2'b00) begin
                dec.kind   = UOP_BRANCH;
                dec.is_bne = ins[12];
                dec.imm    = imm_b;
            end
            OPC_JAL: begin
                dec.kind = UOP_JAL;
                dec.rd   = ins[11:7];
                dec.imm  = imm_j;
            end
            OPC_LOAD: if (ins[14:12] == 3'b011) begin
                dec.kind = UOP_LOAD;
                dec.rd   = ins[11:7];
                dec.imm  = imm_i;
            end
            OPC_STORE: if (ins[14:12] == 3'b011) begin
                dec.kind = UOP_STORE;
                dec.imm  = imm_s;
            end
            default: dec.kind = UOP_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            uop <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            ibuffer_ready <= 1'b0;
            mem_stall     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    ibuffer_ready <= !fire;
                    if (fire) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (uop.kind == UOP_NOP) begin
                        // nothing to execute, retire right away
                        state         <= S_IDLE;
                        ibuffer_ready <= 1'b1;
                    end else begin
                        state     <= S_WAIT;
                        mem_stall <= (uop.kind == UOP_LOAD) || (uop.kind == UOP_STORE);
                    end
                end
                default: begin
                    if (retire) begin
                        state         <= S_IDLE;
                        ibuffer_ready <= 1'b1;
                        mem_stall     <= 1'b0;
                    end
                end
            endcase
        end
    end

    assign alu_issue = (state == S_ISSUE) && (uop.kind inside {UOP_ALU, UOP_BRANCH, UOP_JAL});
    assign mem_issue = (state == S_ISSUE) && (uop.kind inside {UOP_LOAD, UOP_STORE});

endmodule

// File: design/backend_pkg.sv
`include "backend_defs.svh"

package backend_pkg;

    typedef logic [`BE_XLEN-1:0]   xlen_t;
    typedef logic [`BE_ILEN-1:0]   instr_t;
    typedef logic [`BE_AREG_W-1:0] areg_t;

    typedef enum logic [2:0] {
        UOP_NOP, UOP_ALU, UOP_BRANCH, UOP_JAL, UOP_LOAD, UOP_STORE
    } uop_kind_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    // decoded instruction, rd is zero for ops that write nothing
    typedef struct packed {
        uop_kind_e kind;
        alu_op_e   alu_op;
        areg_t     rs1;
        areg_t     rs2;
        areg_t     rd;
        logic      use_imm;
        logic      is_bne;
        xlen_t     pc;
        xlen_t     imm;
    } uop_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
        xlen_t data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

// File: design/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// datapath and instruction widths
`define BE_XLEN   64
`define BE_ILEN   32

// architectural register file
`define BE_NREG   32
`define BE_AREG_W 5

// one byte lane per byte of a doubleword
`define BE_SEL_W  8

`endif
